// File: src.f
dbg_bus_pkg.sv
dbg_core_pkg.sv
dbg_bus_decode.sv
dbg_regs.sv
dbg_halt_ctrl.sv
dbg_unit_top.sv
dbg_unit_sva.sv
tb_dbg_unit.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_dbg_unit -f src.f -o vsim \
  && ./obj_dir/vsim > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: tb_dbg_unit.sv
module tb_dbg_unit import dbg_bus_pkg::*, dbg_core_pkg::*; ();

  localparam int        TMO     = 16;            // Cycles per wait loop
  localparam dbg_addr_t A_CTRL  = 15'h0000;
  localparam dbg_addr_t A_HIT   = 15'h0004;
  localparam dbg_addr_t A_IE    = 15'h0008;
  localparam dbg_addr_t A_CAUSE = 15'h000C;
  localparam dbg_addr_t A_NPC   = 15'h2000;      // Also DNPC on write
  localparam dbg_addr_t A_PPC   = 15'h2004;
  localparam dbg_addr_t A_UNMAP = 15'h1000;      // Region 0x10, nothing there
  localparam dbg_data_t PC_IF   = 32'h0000_1A40;
  localparam dbg_data_t PC_ID   = 32'h0000_1A3C;

  logic clk, rst_n, debug_req_i, debug_gnt_o, debug_rvalid_o, debug_we_i;
  logic debug_halted_o, debug_halt_i, debug_resume_i, trap_i, stall_o;
  logic dbg_req_o, dbg_ack_i, regfile_rreq_o, regfile_wreq_o, jump_req_o;
  dbg_addr_t debug_addr_i;
  dbg_data_t debug_wdata_i, debug_rdata_o, regfile_rdata_i, regfile_wdata_o;
  dbg_data_t pc_if_i, pc_id_i, jump_addr_o;
  logic [4:0] regfile_raddr_o, regfile_waddr_o;
  dbg_settings_t settings_o;
  dbg_cause_t exc_cause_i;

  int errors, checks, err_mark, tests_run, tests_bad;
  logic [31:0] rng;                              // Stimulus generator state
  logic [31:0] rf [32];                          // Register file model
  logic dp_jump, dp_rreq;                        // Seen in the data phase
  dbg_data_t dp_jaddr;

  dbg_unit_top #(.REG_ADDR_WIDTH(5)) u_dut (.*);

  bind dbg_unit_top dbg_unit_sva u_sva (.clk(clk), .rst_n(rst_n), .debug_req_i(debug_req_i),
    .debug_gnt_o(debug_gnt_o), .debug_rvalid_o(debug_rvalid_o), .debug_addr_i(debug_addr_i),
    .stall_o(stall_o), .dbg_req_o(dbg_req_o), .dbg_ack_i(dbg_ack_i));

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] rf_fill(input int i);
    return 32'hA500_0000 ^ (32'(i) * 32'h0001_0203);   // Every index bit counts
  endfunction

  function automatic dbg_addr_t gpr_addr(input logic [4:0] r);
    return {1'b0, 6'h04, 1'b0, r, 2'b00};
  endfunction

  // IE read back: ELSU shows on both 7 and 5
  function automatic dbg_data_t ie_expect(input dbg_data_t v);
    dbg_data_t r;
    r = '0;
    r[11] = v[11];
    r[7] = v[7] | v[5];
    r[5] = v[7] | v[5];
    r[3] = v[3];
    r[2] = v[2];
    return r;
  endfunction

  function automatic dbg_data_t cause_expect(input dbg_cause_t c);
    dbg_data_t r;
    r = '0;
    r[31] = c[5];                                // Interrupt flag on top
    r[4:0] = c[4:0];
    return r;
  endfunction

  //----------------------------------------------------------------------
  // Core models
  //----------------------------------------------------------------------
  assign regfile_rdata_i = rf[regfile_raddr_o];  // Same cycle answer

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) rf[i] <= rf_fill(i);
    end else if (regfile_wreq_o) begin
      rf[regfile_waddr_o] <= regfile_wdata_o;
    end
  end

  initial begin : ack_model
    logic [31:0] ack_rng;
    ack_rng   = 32'd95270;
    dbg_ack_i = 1'b0;
    forever begin
      @(posedge clk);
      if (dbg_req_o) begin
        ack_rng = xorshift(ack_rng);
        repeat (32'(ack_rng[1:0]) + 1) @(negedge clk);   // 1 to 4 cycles late
        dbg_ack_i = 1'b1;
        @(negedge clk);
        dbg_ack_i = 1'b0;
      end
    end
  end

  //----------------------------------------------------------------------
  // Bus and check tasks
  //----------------------------------------------------------------------
  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at time %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic bus(input logic we, input dbg_addr_t a, input dbg_data_t v,
                     output dbg_data_t d);
    int n;
    debug_req_i   = 1'b1;
    debug_we_i    = we;
    debug_addr_i  = a;
    debug_wdata_i = v;
    @(posedge clk);
    check(32'(debug_gnt_o), 32'h1, "gnt in the request cycle");
    @(negedge clk);
    n = 0;
    while (!debug_rvalid_o && n < TMO) begin
      debug_req_i = 1'b0;
      @(negedge clk);
      n++;
    end
    d        = debug_rdata_o;
    dp_jump  = jump_req_o;
    dp_jaddr = jump_addr_o;
    dp_rreq  = regfile_rreq_o;
    debug_req_i = 1'b0;
    debug_we_i  = 1'b0;
    if (!debug_rvalid_o) begin
      errors++;
      $display("Timeout at time %0t: no read-valid for address %h", $time, a);
    end else begin
      check(n, 0, "rvalid one cycle after gnt");
    end
  endtask

  task automatic rd(input dbg_addr_t a, output dbg_data_t d);
    bus(1'b0, a, '0, d);
  endtask

  task automatic wr(input dbg_addr_t a, input dbg_data_t v);
    dbg_data_t unused;
    bus(1'b1, a, v, unused);
  endtask

  // Core must see dbg_req_o until it acks
  task automatic wait_halt();
    int n;
    n = 0;
    while (!debug_halted_o && n < TMO) begin
      check(32'(dbg_req_o), 32'h1, "dbg_req_o held until ack");
      @(negedge clk);
      n++;
    end
    if (!debug_halted_o) begin
      errors++;
      $display("Timeout at time %0t: core never reached the halted state", $time);
    end
    check(32'(dbg_req_o), 32'h0, "dbg_req_o low once halted");
    check(32'(stall_o), 32'h1, "stall_o while halted");
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != err_mark) tests_bad++;
    $display("Test %s done with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  //----------------------------------------------------------------------
  // Tests
  //----------------------------------------------------------------------
  task automatic test_handshake();
    dbg_data_t d;
    rd(A_CTRL, d);
    check(d, 32'h0, "ctrl after reset");
    rd(A_UNMAP, d);
    check(d, 32'h0, "unmapped region reads zero");
    rd(gpr_addr(5'd3), d);
    check(d, 32'h0, "GPR read while running");
    check(32'(dp_rreq), 32'h0, "no regfile read while running");
    rd(A_CAUSE, d);
    check(d, cause_expect(CAUSE_HALT), "cause after reset");
    finish_test("handshake");
  endtask

  task automatic test_ie();
    dbg_data_t d;
    repeat (4) begin
      rng = xorshift(rng);
      wr(A_IE, rng);
      rd(A_IE, d);
      check(d, ie_expect(rng), "IE read back");
      check(32'(settings_o[4:1]), 32'({rng[2], rng[3], rng[7] | rng[5], rng[11]}),
            "settings from IE");
    end
    finish_test("ie_register");
  endtask

  task automatic test_halt_resume();
    dbg_data_t d;
    wr(A_CTRL, 32'h0001_0000);
    check(32'(dbg_req_o), 32'h1, "dbg_req_o after halt write");
    wait_halt();
    rd(A_CTRL, d);
    check(d, 32'h0001_0000, "ctrl shows halted");
    rd(A_CAUSE, d);
    check(d, cause_expect(CAUSE_HALT), "cause after halt write");
    wr(A_CTRL, 32'h0);                           // Resume
    check(32'(debug_halted_o), 32'h0, "halted cleared by resume");
    check(32'(stall_o), 32'h0, "stall cleared by resume");
    finish_test("halt_resume");
  endtask

  task automatic test_trap_step();
    dbg_data_t d;
    dbg_cause_t c;
    wr(A_CTRL, 32'h1);                           // Single step on
    check(32'(settings_o[SETS_SSTE]), 32'h1, "SSTE set by ctrl");
    rng = xorshift(rng);
    c = rng[5:0];
    if (c == CAUSE_HALT) begin
      c = 6'h02;                                 // Must differ from the halt cause
    end
    trap_i      = 1'b1;
    exc_cause_i = c;
    @(negedge clk);
    trap_i = 1'b0;
    wait_halt();
    rd(A_CAUSE, d);
    check(d, cause_expect(c), "cause after trap");
    rd(A_HIT, d);
    check(d, 32'h1, "hit flag after step trap");
    wr(A_HIT, 32'h1);
    rd(A_HIT, d);
    check(d, 32'h0, "hit flag cleared by write");
    wr(A_CTRL, 32'h0);
    finish_test("trap_step");
  endtask

  task automatic test_halted_access();
    dbg_data_t d;
    dbg_data_t v;
    logic [4:0] r;
    rng = xorshift(rng);
    v = rng;
    r = rng[12:8] | 5'd1;                        // Any register but x0
    // Running: nothing reaches the core
    wr(gpr_addr(r), v);
    check(rf[r], rf_fill(int'(r)), "GPR write ignored while running");
    wr(A_NPC, v);
    check(32'(dp_jump), 32'h0, "no jump while running");
    rd(A_NPC, d);
    check(d, 32'h0, "NPC hidden while running");
    wr(A_CTRL, 32'h0001_0000);
    wait_halt();
    wr(gpr_addr(r), v);
    check(rf[r], v, "GPR write reached regfile");
    rd(gpr_addr(r), d);
    check(d, v, "GPR read back");
    check(32'(dp_rreq), 32'h1, "regfile read in data phase");
    rd(A_NPC, d);
    check(d, PC_IF, "NPC read");
    rd(A_PPC, d);
    check(d, PC_ID, "PPC read");
    v = xorshift(v) & 32'hFFFF_FFFC;
    wr(A_NPC, v);
    check(32'(dp_jump), 32'h1, "jump on DNPC write");
    check(dp_jaddr, v, "jump address");
    @(negedge clk);
    check(32'(jump_req_o), 32'h0, "jump lasts one cycle");
    wr(A_CTRL, 32'h0);
    finish_test("halted_access");
  endtask

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------
  initial begin
    errors = 0;
    checks = 0;
    err_mark = 0;
    tests_run = 0;
    tests_bad = 0;
    rng = 32'd95270;
    rst_n = 1'b0;
    debug_req_i = 1'b0;
    debug_we_i = 1'b0;
    debug_addr_i = '0;
    debug_wdata_i = '0;
    debug_halt_i = 1'b0;
    debug_resume_i = 1'b0;
    trap_i = 1'b0;
    exc_cause_i = '0;
    pc_if_i = PC_IF;
    pc_id_i = PC_ID;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_handshake();
    test_ie();
    test_halt_resume();
    test_trap_step();
    test_halted_access();
    errors += int'(u_dut.u_sva.sva_errs);
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: dbg_unit_sva.sv
module dbg_unit_sva import dbg_bus_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      debug_req_i,
  input logic      debug_gnt_o,
  input logic      debug_rvalid_o,
  input dbg_addr_t debug_addr_i,
  input logic      stall_o,
  input logic      dbg_req_o,
  input logic      dbg_ack_i
);

  int unsigned sva_errs = 0;   // Failed assertion count

  //----------------------------------------------------------------------
  // Bus protocol
  //----------------------------------------------------------------------
  a_rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    debug_gnt_o |=> debug_rvalid_o)
    else begin
      sva_errs++;
      $error("rvalid did not follow gnt by one cycle");
    end

  a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    debug_req_i |-> (debug_addr_i[1:0] == 2'b00))   // Byte address, word access
    else begin
      sva_errs++;
      $error("debug request address not word aligned");
    end

  //----------------------------------------------------------------------
  // Core stall
  //----------------------------------------------------------------------
  // Stall only starts once the core acked a pending request
  a_stall_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(stall_o) |-> $past(dbg_req_o && dbg_ack_i))
    else begin
      sva_errs++;
      $error("stall_o rose without an acked halt request");
    end

endmodule

// File: dbg_unit_top.sv
module dbg_unit_top import dbg_bus_pkg::*, dbg_core_pkg::*; #(
  parameter int REG_ADDR_WIDTH = 5
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // Debug bus
  input  logic                      debug_req_i,
  output logic                      debug_gnt_o,
  output logic                      debug_rvalid_o,
  input  dbg_addr_t                 debug_addr_i,
  input  logic                      debug_we_i,
  input  dbg_data_t                 debug_wdata_i,
  output dbg_data_t                 debug_rdata_o,
  // Halt/resume pins
  output logic                      debug_halted_o,
  input  logic                      debug_halt_i,
  input  logic                      debug_resume_i,
  // Core side
  output dbg_settings_t             settings_o,
  input  logic                      trap_i,
  input  dbg_cause_t                exc_cause_i,
  output logic                      stall_o,
  output logic                      dbg_req_o,
  input  logic                      dbg_ack_i,
  // Register file read port
  output logic                      regfile_rreq_o,
  output logic [REG_ADDR_WIDTH-1:0] regfile_raddr_o,
  input  dbg_data_t                 regfile_rdata_i,
  // Register file write port
  output logic                      regfile_wreq_o,
  output logic [REG_ADDR_WIDTH-1:0] regfile_waddr_o,
  output dbg_data_t                 regfile_wdata_o,
  // NPC/PPC and jump
  input  dbg_data_t                 pc_if_i,
  input  dbg_data_t                 pc_id_i,
  output logic                      jump_req_o,
  output dbg_data_t                 jump_addr_o
);

  //----------------------------------------------------------------------
  // Internal wires
  //----------------------------------------------------------------------
  rdata_sel_e rdata_sel;
  logic [4:0] reg_idx;
  logic       halt_cmd;
  logic       resume_cmd;
  logic       hit_clr;
  logic       ctrl_we;
  logic       ie_we;
  dbg_data_t  wdata;
  dbg_cause_t cause;
  logic       ssth;

  dbg_bus_decode #(
    .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
  ) u_decode (
    .clk             (clk),
    .rst_n           (rst_n),
    .debug_req_i     (debug_req_i),
    .debug_addr_i    (debug_addr_i),
    .debug_we_i      (debug_we_i),
    .debug_wdata_i   (debug_wdata_i),
    .debug_gnt_o     (debug_gnt_o),
    .debug_rvalid_o  (debug_rvalid_o),
    .halted_i        (debug_halted_o),
    .rdata_sel_o     (rdata_sel),
    .reg_idx_o       (reg_idx),
    .halt_cmd_o      (halt_cmd),
    .resume_cmd_o    (resume_cmd),
    .hit_clr_o       (hit_clr),
    .ctrl_we_o       (ctrl_we),
    .ie_we_o         (ie_we),
    .wdata_o         (wdata),
    .regfile_rreq_o  (regfile_rreq_o),
    .regfile_raddr_o (regfile_raddr_o),
    .regfile_wreq_o  (regfile_wreq_o),
    .regfile_waddr_o (regfile_waddr_o),
    .regfile_wdata_o (regfile_wdata_o),
    .jump_req_o      (jump_req_o),
    .jump_addr_o     (jump_addr_o)
  );

  dbg_regs u_regs (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_we_i       (ctrl_we),
    .ie_we_i         (ie_we),
    .wdata_i         (wdata),
    .rdata_sel_i     (rdata_sel),
    .reg_idx_i       (reg_idx),
    .halted_i        (debug_halted_o),
    .cause_i         (cause),
    .ssth_i          (ssth),
    .pc_if_i         (pc_if_i),
    .pc_id_i         (pc_id_i),
    .regfile_rdata_i (regfile_rdata_i),
    .settings_o      (settings_o),
    .debug_rdata_o   (debug_rdata_o)
  );

  dbg_halt_ctrl u_halt (
    .clk             (clk),
    .rst_n           (rst_n),
    .halt_cmd_i      (halt_cmd),
    .resume_cmd_i    (resume_cmd),
    .hit_clr_i       (hit_clr),
    .debug_halt_i    (debug_halt_i),
    .debug_resume_i  (debug_resume_i),
    .trap_i          (trap_i),
    .exc_cause_i     (exc_cause_i),
    .settings_i      (settings_o),
    .dbg_ack_i       (dbg_ack_i),
    .dbg_req_o       (dbg_req_o),
    .stall_o         (stall_o),
    .halted_o        (debug_halted_o),
    .cause_o         (cause),
    .ssth_o          (ssth)
  );

endmodule

// File: dbg_halt_ctrl.sv
module dbg_halt_ctrl import dbg_core_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  // From the bus decoder
  input  logic          halt_cmd_i,
  input  logic          resume_cmd_i,
  input  logic          hit_clr_i,
  // Direct pins
  input  logic          debug_halt_i,
  input  logic          debug_resume_i,
  // Core events
  input  logic          trap_i,
  input  dbg_cause_t    exc_cause_i,
  input  dbg_settings_t settings_i,
  // Core handshake
  input  logic          dbg_ack_i,
  output logic          dbg_req_o,
  output logic          stall_o,
  output logic          halted_o,
  output dbg_cause_t    cause_o,
  output logic          ssth_o
);

  typedef enum logic [1:0] {
    RUNNING,
    HALT_REQ,
    HALT
  } halt_state_e;

  halt_state_e state_q;
  halt_state_e state_n;
  dbg_cause_t  cause_q;
  dbg_cause_t  cause_n;
  logic        ssth_q;
  logic        ssth_n;
  logic        halt_ev;   // Any reason to stop
  logic        resume;

  assign halt_ev = halt_cmd_i | debug_halt_i | trap_i;
  assign resume  = resume_cmd_i | debug_resume_i;

  //----------------------------------------------------------------------
  // Halt FSM
  //----------------------------------------------------------------------
  always_comb begin
    state_n   = state_q;
    cause_n   = cause_q;
    ssth_n    = ssth_q;
    dbg_req_o = 1'b0;
    halted_o  = 1'b0;
    case (state_q)
      RUNNING: begin
        ssth_n = 1'b0;
        if (halt_ev) begin
          dbg_req_o = 1'b1;                       // Same cycle as the event
          state_n   = HALT_REQ;
          if (trap_i) begin
            cause_n = exc_cause_i;
            ssth_n  = settings_i[SETS_SSTE];      // Single step hit
          end else begin
            cause_n = CAUSE_HALT;
          end
        end
      end
      HALT_REQ: begin
        dbg_req_o = ~resume;                      // Held until ack
        if (resume) begin
          state_n = RUNNING;                      // Resume beats the ack
          ssth_n  = 1'b0;
        end else if (dbg_ack_i) begin
          state_n = HALT;
        end
      end
      HALT: begin
        halted_o = ~resume;                       // Drops with the resume
        if (resume) begin
          state_n = RUNNING;
          ssth_n  = 1'b0;
        end
      end
      default: state_n = RUNNING;
    endcase
    if (hit_clr_i) begin
      ssth_n = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RUNNING;
      cause_q <= CAUSE_HALT;
      ssth_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      cause_q <= cause_n;
      ssth_q  <= ssth_n;
    end
  end

  assign stall_o = halted_o;   // Core held only while halted
  assign cause_o = cause_q;
  assign ssth_o  = ssth_q;

endmodule

// File: dbg_regs.sv
module dbg_regs import dbg_bus_pkg::*, dbg_core_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  // Write pulses from the decoder
  input  logic          ctrl_we_i,
  input  logic          ie_we_i,
  input  dbg_data_t     wdata_i,
  // Data phase select
  input  rdata_sel_e    rdata_sel_i,
  input  logic [4:0]    reg_idx_i,
  // Read sources
  input  logic          halted_i,
  input  dbg_cause_t    cause_i,
  input  logic          ssth_i,
  input  dbg_data_t     pc_if_i,
  input  dbg_data_t     pc_id_i,
  input  dbg_data_t     regfile_rdata_i,
  output dbg_settings_t settings_o,
  output dbg_data_t     debug_rdata_o
);

  dbg_settings_t settings_q;

  //----------------------------------------------------------------------
  // Settings register
  //----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      settings_q <= '0;
    end else if (ctrl_we_i) begin
      settings_q[SETS_SSTE] <= wdata_i[CTRL_SSTE_BIT];
    end else if (ie_we_i) begin
      settings_q[SETS_ECALL] <= wdata_i[11];
      settings_q[SETS_ELSU]  <= wdata_i[7] | wdata_i[5];   // Load or store fault
      settings_q[SETS_EBRK]  <= wdata_i[3];
      settings_q[SETS_EILL]  <= wdata_i[2];
    end
  end

  assign settings_o = settings_q;

  //----------------------------------------------------------------------
  // Read data, valid with rvalid
  //----------------------------------------------------------------------
  always_comb begin
    debug_rdata_o = '0;
    case (rdata_sel_i)
      RD_DBGA: begin
        case (reg_idx_i)
          IDX_CTRL: begin
            debug_rdata_o[CTRL_HALT_BIT] = halted_i;
            debug_rdata_o[CTRL_SSTE_BIT] = settings_q[SETS_SSTE];
          end
          IDX_HIT: debug_rdata_o[0] = ssth_i;
          IDX_IE: begin
            debug_rdata_o[11] = settings_q[SETS_ECALL];
            debug_rdata_o[7]  = settings_q[SETS_ELSU];     // Mirrored
            debug_rdata_o[5]  = settings_q[SETS_ELSU];
            debug_rdata_o[3]  = settings_q[SETS_EBRK];
            debug_rdata_o[2]  = settings_q[SETS_EILL];
          end
          IDX_CAUSE: debug_rdata_o = {cause_i[5], 26'b0, cause_i[4:0]};
          default: ;                                       // BP ctrl etc read zero
        endcase
      end
      RD_DBGS: begin
        case (reg_idx_i)
          5'd0:    debug_rdata_o = pc_if_i;   // NPC
          5'd1:    debug_rdata_o = pc_id_i;   // PPC
          default: ;
        endcase
      end
      RD_GPR:  debug_rdata_o = regfile_rdata_i;
      default: ;
    endcase
  end

endmodule

// File: dbg_bus_decode.sv
module dbg_bus_decode import dbg_bus_pkg::*; #(
  parameter int REG_ADDR_WIDTH = 5
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // Debug bus
  input  logic                      debug_req_i,
  input  dbg_addr_t                 debug_addr_i,
  input  logic                      debug_we_i,
  input  dbg_data_t                 debug_wdata_i,
  output logic                      debug_gnt_o,
  output logic                      debug_rvalid_o,
  input  logic                      halted_i,
  // Data-phase select for the read mux
  output rdata_sel_e                rdata_sel_o,
  output logic [4:0]                reg_idx_o,
  // Command pulses, grant cycle
  output logic                      halt_cmd_o,
  output logic                      resume_cmd_o,
  output logic                      hit_clr_o,
  output logic                      ctrl_we_o,
  output logic                      ie_we_o,
  output dbg_data_t                 wdata_o,
  // Register file ports
  output logic                      regfile_rreq_o,
  output logic [REG_ADDR_WIDTH-1:0] regfile_raddr_o,
  output logic                      regfile_wreq_o,
  output logic [REG_ADDR_WIDTH-1:0] regfile_waddr_o,
  output dbg_data_t                 regfile_wdata_o,
  // Jump to written NPC
  output logic                      jump_req_o,
  output dbg_data_t                 jump_addr_o
);

  logic [5:0] region;
  logic [4:0] idx;
  logic       mapped;       // Request in the lower, decoded half
  rdata_sel_e rdata_sel_n;
  rdata_sel_e rdata_sel_q;
  logic       rreq_n;
  logic       rreq_q;
  logic       jump_n;
  logic       jump_q;
  logic [4:0] idx_q;
  dbg_data_t  wdata_q;

  assign region      = debug_addr_i[13:8];
  assign idx         = debug_addr_i[6:2];
  assign mapped      = debug_req_i & ~debug_addr_i[14];
  assign debug_gnt_o = debug_req_i;   // Never blocks, invalid ones too

  //----------------------------------------------------------------------
  // Address phase decode
  //----------------------------------------------------------------------
  always_comb begin
    rdata_sel_n    = RD_NONE;
    rreq_n         = 1'b0;
    jump_n         = 1'b0;
    regfile_wreq_o = 1'b0;
    halt_cmd_o     = 1'b0;
    resume_cmd_o   = 1'b0;
    hit_clr_o      = 1'b0;
    ctrl_we_o      = 1'b0;
    ie_we_o        = 1'b0;
    if (mapped && debug_we_i) begin
      case (region)
        REGION_DBGA: begin
          case (idx)
            IDX_CTRL: begin
              ctrl_we_o    = 1'b1;                              // SSTE update
              halt_cmd_o   = debug_wdata_i[CTRL_HALT_BIT];
              resume_cmd_o = ~debug_wdata_i[CTRL_HALT_BIT];
            end
            IDX_HIT: hit_clr_o = debug_wdata_i[0];             // Write 1 to clear
            IDX_IE:  ie_we_o   = 1'b1;
            default: ;
          endcase
        end
        REGION_DBGS: jump_n = halted_i & (idx == 5'd0);        // DNPC
        REGION_GPR:  regfile_wreq_o = halted_i;
        default: ;
      endcase
    end else if (mapped) begin
      case (region)
        REGION_DBGA: rdata_sel_n = RD_DBGA;
        REGION_DBGS: begin
          if (halted_i) begin
            rdata_sel_n = RD_DBGS;
          end
        end
        REGION_GPR: begin
          if (halted_i) begin
            rreq_n      = 1'b1;
            rdata_sel_n = RD_GPR;
          end
        end
        default: ;                                             // Reads as zero
      endcase
    end
  end

  //----------------------------------------------------------------------
  // Data phase registers
  //----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_rvalid_o <= 1'b0;
      rdata_sel_q    <= RD_NONE;
      rreq_q         <= 1'b0;
      jump_q         <= 1'b0;
    end else begin
      debug_rvalid_o <= debug_gnt_o;   // Fixed one cycle after grant
      rdata_sel_q    <= rdata_sel_n;
      rreq_q         <= rreq_n;
      jump_q         <= jump_n;        // Single cycle pulse
    end
  end

  // Payload, only loaded on a request
  always_ff @(posedge clk) begin
    if (debug_req_i) begin
      idx_q   <= idx;
      wdata_q <= debug_wdata_i;
    end
  end

  assign rdata_sel_o     = rdata_sel_q;
  assign reg_idx_o       = idx_q;
  assign wdata_o         = debug_wdata_i;   // Same cycle as the write pulses

  assign regfile_rreq_o  = rreq_q;
  assign regfile_raddr_o = idx_q[REG_ADDR_WIDTH-1:0];
  assign regfile_waddr_o = idx[REG_ADDR_WIDTH-1:0];    // Straight from address phase
  assign regfile_wdata_o = debug_wdata_i;

  assign jump_req_o      = jump_q;
  assign jump_addr_o     = wdata_q;

endmodule

// File: dbg_core_pkg.sv
package dbg_core_pkg;

  //----------------------------------------------------------------------
  // Core-facing settings
  //----------------------------------------------------------------------
  typedef logic [4:0] dbg_settings_t;

  localparam int SETS_SSTE  = 0;   // Single step
  localparam int SETS_ECALL = 1;   // Halt on ecall
  localparam int SETS_ELSU  = 2;   // Halt on load/store fault
  localparam int SETS_EBRK  = 3;   // Halt on ebreak
  localparam int SETS_EILL  = 4;   // Halt on illegal instr

  //----------------------------------------------------------------------
  // Halt cause
  //----------------------------------------------------------------------
  typedef logic [5:0] dbg_cause_t;   // Bit 5 marks an interrupt

  // Explicit halt, from register or pin
  localparam dbg_cause_t CAUSE_HALT = 6'h1F;

endpackage

// File: dbg_bus_pkg.sv
package dbg_bus_pkg;

  //----------------------------------------------------------------------
  // Bus-side types
  //----------------------------------------------------------------------
  typedef logic [14:0] dbg_addr_t;   // Byte address, upper half unmapped
  typedef logic [31:0] dbg_data_t;   // Bus or register word

  // Read source held for the data phase
  typedef enum logic [2:0] {
    RD_NONE,
    RD_GPR,
    RD_DBGA,
    RD_DBGS
  } rdata_sel_e;

  //----------------------------------------------------------------------
  // Register map
  //----------------------------------------------------------------------
  // Regions on addr[13:8]
  localparam logic [5:0] REGION_DBGA = 6'h00;   // Always visible
  localparam logic [5:0] REGION_DBGS = 6'h20;   // Halted only, NPC/PPC
  localparam logic [5:0] REGION_GPR  = 6'h04;   // Register file, halted only

  // Word index on addr[6:2] inside DBGA
  localparam logic [4:0] IDX_CTRL  = 5'd0;
  localparam logic [4:0] IDX_HIT   = 5'd1;
  localparam logic [4:0] IDX_IE    = 5'd2;
  localparam logic [4:0] IDX_CAUSE = 5'd3;

  // Control register fields
  localparam int CTRL_HALT_BIT = 16;
  localparam int CTRL_SSTE_BIT = 0;

endpackage
